// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_x25519_ladder_step -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qx "Done: no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== source/fe_addsub.sv ====
`timescale 1ns/100ps

module fe_addsub (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               start,
	input  x25519_pkg::fe_op_t op,
	output x25519_pkg::fe_t    res,
	output logic               done
);
	import x25519_pkg::*;

	// raw sum, never above 2p - 2 so it fits in fe_t
	fe_t sum;
	fe_t sum_red;
	// one extra bit to catch the borrow of a - b
	logic [FE_W+1:0] diff;
	fe_t diff_red;
	fe_t res_nxt;

	//////////////////////////////
	// combinational add / sub
	//////////////////////////////

	always_comb begin
		sum = op.a + op.b;
		// single conditional subtract is enough for reduced inputs
		sum_red = (sum >= FIELD_P) ? sum - FIELD_P : sum;

		diff = {1'b0, op.a} - {1'b0, op.b};
		// borrow out means a < b, wrap back into range
		diff_red = diff[FE_W+1] ? diff[FE_W:0] + FIELD_P : diff[FE_W:0];

		res_nxt = op.sub ? diff_red : sum_red;
	end

	//////////////////////////////
	// output registers
	//////////////////////////////

	// done one cycle after start
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done <= 1'b0;
		end else begin
			done <= start;
		end
	end

	// result holds until the next start
	always_ff @(posedge clk) begin
		if (start) begin
			res <= res_nxt;
		end
	end

endmodule

// ==== source/fe_mult.sv ====
`timescale 1ns/100ps

module fe_mult (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               start,
	input  x25519_pkg::fe_op_t op,
	output x25519_pkg::fe_t    res,
	output logic               done
);
	import x25519_pkg::*;

	// wide enough to hold FE_W
	typedef logic [$clog2(FE_W+1)-1:0] cnt_t;

	// sequencing
	logic busy;
	cnt_t cnt;

	// datapath
	fe_t a_q;
	fe_t b_sh;
	fe_t acc;
	fe_t acc_dbl;
	fe_t acc_nxt;

	// one conditional subtract of p, input below 2p
	function automatic fe_t fold(input fe_t v);
		return (v >= FIELD_P) ? v - FIELD_P : v;
	endfunction

	//////////////////////////////
	// one interleaved step
	//////////////////////////////

	always_comb begin
		// acc < p < 2^255, so the shift cannot lose a bit
		acc_dbl = fold({acc[FE_W-1:0], 1'b0});
		// msb first, bit FE_W of b is always zero
		acc_nxt = b_sh[FE_W-1] ? fold(acc_dbl + a_q) : acc_dbl;
	end

	//////////////////////////////
	// step counter
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt  <= cnt_t'(FE_W);
			end else if (busy) begin
				cnt <= cnt - 1'b1;
				// last step, done lands FE_W+1 cycles after start
				if (cnt == cnt_t'(1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// operands and accumulator
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (start) begin
			a_q  <= op.a;
			b_sh <= op.b;
			acc  <= '0;
		end else if (busy) begin
			acc  <= acc_nxt;
			b_sh <= b_sh << 1;
		end
	end

	// accumulator stays put once busy drops
	assign res = acc;

endmodule

// ==== source/ladder_step_ctrl.sv ====
`timescale 1ns/100ps

module ladder_step_ctrl (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    start,
	input  x25519_pkg::fe_t         x1,
	input  x25519_pkg::point_pair_t pts_in,
	input  logic                    swap,
	output x25519_pkg::point_pair_t pts_out,
	output logic                    done,
	output logic                    as_start,
	output x25519_pkg::fe_op_t      as_op,
	input  x25519_pkg::fe_t         as_res,
	input  logic                    as_done,
	output logic                    mul_start,
	output x25519_pkg::fe_op_t      mul_op,
	input  x25519_pkg::fe_t         mul_res,
	input  logic                    mul_done
);
	import x25519_pkg::*;

	// each state waits for the value it is named after
	// order matters, the walk is state + 1
	typedef enum logic [4:0] {
		ST_IDLE, ST_A, ST_B, ST_C, ST_D, ST_AA, ST_BB, ST_E, ST_DA,
		ST_CB, ST_SUM, ST_DIF, ST_X3, ST_SQ, ST_Z3, ST_X2, ST_M, ST_U, ST_Z2
	} state_t;

	state_t state;
	state_t nxt;
	logic   step;

	// latched inputs, points already exchanged
	fe_t         x1_q;
	logic        swap_q;
	point_pair_t cur;

	// formula temporaries
	fe_t t_a, t_b, t_c, t_d;
	fe_t t_aa, t_bb, t_e;
	fe_t t_da, t_cb, t_sum, t_dif, t_sq;
	fe_t t_m, t_u;
	// finished coordinates of the new pair
	fe_t nx2, nx3, nz3;
	point_pair_t fresh;

	// states entered with a multiply in flight
	function automatic logic waits_mul(input state_t s);
		return s inside {ST_AA, ST_BB, ST_DA, ST_CB, ST_X3, ST_SQ, ST_Z3, ST_X2, ST_M, ST_Z2};
	endfunction

	// states that launch an add/sub on entry
	function automatic logic issues_as(input state_t s);
		return s inside {ST_A, ST_B, ST_C, ST_D, ST_E, ST_SUM, ST_DIF, ST_U};
	endfunction

	// states that launch a multiply on entry
	function automatic logic issues_mul(input state_t s);
		return s inside {ST_C, ST_BB, ST_DA, ST_CB, ST_DIF, ST_SQ, ST_Z3, ST_X2, ST_M, ST_Z2};
	endfunction

	function automatic fe_op_t mk_op(input fe_t opa, input fe_t opb, input logic is_sub);
		return '{a: opa, b: opb, sub: is_sub};
	endfunction

	//////////////////////////////
	// sequencing
	//////////////////////////////

	always_comb begin
		nxt = (state == ST_Z2) ? ST_IDLE : state_t'(state + 1'b1);
		if (state == ST_IDLE) begin
			step = start;
		end else if (waits_mul(state)) begin
			step = mul_done;
		end else begin
			step = as_done;
		end
	end

	// Z2 arrives straight from the multiplier on the last step
	always_comb begin
		fresh.p0.x = nx2;
		fresh.p0.z = mul_res;
		fresh.p1.x = nx3;
		fresh.p1.z = nz3;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			as_start  <= 1'b0;
			mul_start <= 1'b0;
			done      <= 1'b0;
			pts_out   <= '0;
		end else begin
			as_start  <= 1'b0;
			mul_start <= 1'b0;
			done      <= 1'b0;
			if (step) begin
				state     <= nxt;
				as_start  <= issues_as(nxt);
				mul_start <= issues_mul(nxt);
				// swap back under the same bit
				if (state == ST_Z2) begin
					done    <= 1'b1;
					pts_out <= swap_q ? '{p0: fresh.p1, p1: fresh.p0} : fresh;
				end
			end
		end
	end

	//////////////////////////////
	// capture of results
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (step) begin
			case (state)
				ST_IDLE: begin
					x1_q   <= x1;
					swap_q <= swap;
					cur    <= swap ? '{p0: pts_in.p1, p1: pts_in.p0} : pts_in;
				end
				ST_A:   t_a   <= as_res;
				ST_B:   t_b   <= as_res;
				ST_C:   t_c   <= as_res;
				ST_D:   t_d   <= as_res;
				ST_AA:  t_aa  <= mul_res;
				ST_BB:  t_bb  <= mul_res;
				ST_E:   t_e   <= as_res;
				ST_DA:  t_da  <= mul_res;
				ST_CB:  t_cb  <= mul_res;
				ST_SUM: t_sum <= as_res;
				ST_DIF: t_dif <= as_res;
				ST_X3:  nx3   <= mul_res;
				ST_SQ:  t_sq  <= mul_res;
				ST_Z3:  nz3   <= mul_res;
				ST_X2:  nx2   <= mul_res;
				ST_M:   t_m   <= mul_res;
				ST_U:   t_u   <= as_res;
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// operand select
	//////////////////////////////

	// units sample on their start pulse, the first cycle of each state
	always_comb begin
		as_op  = '0;
		mul_op = '0;
		case (state)
			// A, B from (X2:Z2)
			ST_A: as_op = mk_op(cur.p0.x, cur.p0.z, 1'b0);
			ST_B: as_op = mk_op(cur.p0.x, cur.p0.z, 1'b1);
			// C, D from (X3:Z3) while A is squared
			ST_C: begin
				as_op  = mk_op(cur.p1.x, cur.p1.z, 1'b0);
				mul_op = mk_op(t_a, t_a, 1'b0);
			end
			ST_D:   as_op  = mk_op(cur.p1.x, cur.p1.z, 1'b1);
			ST_BB:  mul_op = mk_op(t_b, t_b, 1'b0);
			ST_E:   as_op  = mk_op(t_aa, t_bb, 1'b1);
			ST_DA:  mul_op = mk_op(t_d, t_a, 1'b0);
			ST_CB:  mul_op = mk_op(t_c, t_b, 1'b0);
			ST_SUM: as_op  = mk_op(t_da, t_cb, 1'b0);
			// X3' squares the sum while the difference is formed
			ST_DIF: begin
				as_op  = mk_op(t_da, t_cb, 1'b1);
				mul_op = mk_op(t_sum, t_sum, 1'b0);
			end
			ST_SQ:  mul_op = mk_op(t_dif, t_dif, 1'b0);
			ST_Z3:  mul_op = mk_op(x1_q, t_sq, 1'b0);
			ST_X2:  mul_op = mk_op(t_aa, t_bb, 1'b0);
			// a24 product goes through the shared multiplier
			ST_M:   mul_op = mk_op(A24, t_e, 1'b0);
			ST_U:   as_op  = mk_op(t_aa, t_m, 1'b0);
			ST_Z2:  mul_op = mk_op(t_e, t_u, 1'b0);
			default: ;
		endcase
	end

endmodule

// ==== source/x25519_ladder_step.sv ====
`timescale 1ns/100ps

module x25519_ladder_step (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    start,
	input  x25519_pkg::fe_t         x1,
	input  x25519_pkg::point_pair_t pts_in,
	input  logic                    swap,
	output x25519_pkg::point_pair_t pts_out,
	output logic                    done
);
	import x25519_pkg::*;

	// add/subtract unit link
	logic   as_start;
	fe_op_t as_op;
	fe_t    as_res;
	logic   as_done;

	// multiplier link
	logic   mul_start;
	fe_op_t mul_op;
	fe_t    mul_res;
	logic   mul_done;

	//////////////////////////////
	// sequencer
	//////////////////////////////

	ladder_step_ctrl u_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (start),
		.x1        (x1),
		.pts_in    (pts_in),
		.swap      (swap),
		.pts_out   (pts_out),
		.done      (done),
		.as_start  (as_start),
		.as_op     (as_op),
		.as_res    (as_res),
		.as_done   (as_done),
		.mul_start (mul_start),
		.mul_op    (mul_op),
		.mul_res   (mul_res),
		.mul_done  (mul_done)
	);

	//////////////////////////////
	// shared field units
	//////////////////////////////

	// single cycle, shared by every add and subtract
	fe_addsub u_addsub (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (as_start),
		.op     (as_op),
		.res    (as_res),
		.done   (as_done)
	);

	// FE_W+1 cycles per product, squares and a24 included
	fe_mult u_mult (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (mul_start),
		.op     (mul_op),
		.res    (mul_res),
		.done   (mul_done)
	);

endmodule

// ==== source/x25519_pkg.sv ====
package x25519_pkg;

	//////////////////////////////
	// field parameters
	//////////////////////////////

	// bits per field element, also the multiplier step count
	localparam int FE_W = 255;

	// one spare top bit so a sum of two reduced values fits
	typedef logic [FE_W:0] fe_t;

	// p = 2^255 - 19
	localparam fe_t FIELD_P = (fe_t'(1) << FE_W) - fe_t'(19);

	// (486662 - 2) / 4, used in the doubling half of the step
	localparam fe_t A24 = fe_t'(121665);

	//////////////////////////////
	// shared structs
	//////////////////////////////

	// projective point (X:Z)
	typedef struct packed {
		fe_t x;
		fe_t z;
	} xz_point_t;

	// ladder state
	// p0 is (X2:Z2), p1 is (X3:Z3)
	typedef struct packed {
		xz_point_t p0;
		xz_point_t p1;
	} point_pair_t;

	// request to one of the field units
	// sub only matters to the add/subtract unit
	typedef struct packed {
		fe_t  a;
		fe_t  b;
		logic sub;
	} fe_op_t;

endpackage

// ==== verif/tb_x25519_ladder_step.sv ====
`timescale 1ns/100ps

module tb_x25519_ladder_step;
	import x25519_pkg::*;

	// 30 steps near 2.6k cycles each, plus the quiet tail after the busy test
	localparam int MAX_CYCLES = 100000;

	logic        clk = 1'b0;
	logic        arst_n;
	logic        start;
	fe_t         x1;
	point_pair_t pts_in;
	logic        swap;
	point_pair_t pts_out;
	logic        done;

	integer seed;
	int     errors = 0;
	int     checks = 0;
	int     cycles = 0;

	// one entry per accepted start, popped on done
	point_pair_t exp_q[$];
	string       name_q[$];
	point_pair_t exp_pt;
	string       exp_name;

	x25519_ladder_step UUT (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (start),
		.x1      (x1),
		.pts_in  (pts_in),
		.swap    (swap),
		.pts_out (pts_out),
		.done    (done)
	);

	// 4 ns period
	always #2 clk = ~clk;

	//////////////////////////////
	// reference field arithmetic
	//////////////////////////////

	function automatic fe_t add_mod(input fe_t a, input fe_t b);
		fe_t s;
		s = a + b;
		if (s >= FIELD_P) begin
			s = s - FIELD_P;
		end
		return s;
	endfunction

	function automatic fe_t sub_mod(input fe_t a, input fe_t b);
		if (a >= b) begin
			return a - b;
		end
		// a + p stays below 2^256
		return a + FIELD_P - b;
	endfunction

	// lsb first, a doubled every bit
	function automatic fe_t mul_mod(input fe_t a, input fe_t b);
		fe_t r;
		fe_t x;
		r = '0;
		x = a;
		for (int i = 0; i < FE_W; i++) begin
			if (b[i]) begin
				r = add_mod(r, x);
			end
			x = add_mod(x, x);
		end
		return r;
	endfunction

	// top bit dropped, then below 2p so one subtract
	function automatic fe_t reduce(input fe_t v);
		fe_t t;
		t = {1'b0, v[FE_W-1:0]};
		return (t >= FIELD_P) ? t - FIELD_P : t;
	endfunction

	function automatic fe_t rand_fe();
		fe_t v;
		for (int k = 0; k < 8; k++) begin
			v[k*32 +: 32] = $random(seed);
		end
		return reduce(v);
	endfunction

	function automatic point_pair_t rand_pair();
		point_pair_t pp;
		pp.p0.x = rand_fe();
		pp.p0.z = rand_fe();
		pp.p1.x = rand_fe();
		pp.p1.z = rand_fe();
		return pp;
	endfunction

	// swap, RFC 7748 ladder formulas, swap back
	function automatic point_pair_t ladder_ref(input fe_t xb, input point_pair_t pp,
			input logic sw);
		point_pair_t w;
		point_pair_t r;
		fe_t a, b, c, d, aa, bb, e, da, cb;
		w = pp;
		if (sw) begin
			w.p0 = pp.p1;
			w.p1 = pp.p0;
		end
		a  = add_mod(w.p0.x, w.p0.z);
		b  = sub_mod(w.p0.x, w.p0.z);
		c  = add_mod(w.p1.x, w.p1.z);
		d  = sub_mod(w.p1.x, w.p1.z);
		aa = mul_mod(a, a);
		bb = mul_mod(b, b);
		e  = sub_mod(aa, bb);
		da = mul_mod(d, a);
		cb = mul_mod(c, b);
		r.p1.x = mul_mod(add_mod(da, cb), add_mod(da, cb));
		r.p1.z = mul_mod(xb, mul_mod(sub_mod(da, cb), sub_mod(da, cb)));
		r.p0.x = mul_mod(aa, bb);
		r.p0.z = mul_mod(e, add_mod(aa, mul_mod(A24, e)));
		w = r;
		if (sw) begin
			w.p0 = r.p1;
			w.p1 = r.p0;
		end
		return w;
	endfunction

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	// one-cycle start, expected result queued
	task automatic launch(input string name, input fe_t xb, input point_pair_t pp,
			input logic sw);
		@(negedge clk);
		start  = 1'b1;
		x1     = xb;
		pts_in = pp;
		swap   = sw;
		exp_q.push_back(ladder_ref(xb, pp, sw));
		name_q.push_back(name);
		@(negedge clk);
		start = 1'b0;
	endtask

	// cycle counter bounds the wait
	task automatic wait_done();
		do begin
			@(negedge clk);
		end while (!done);
	endtask

	//////////////////////////////
	// checking and timeout
	//////////////////////////////

	// outputs settled mid-cycle
	always @(negedge clk) begin
		if (arst_n && done) begin
			assert (exp_q.size() > 0) else begin
				errors++;
				$display("done pulsed with no step outstanding at %0t", $time);
			end
			if (exp_q.size() > 0) begin
				exp_pt   = exp_q.pop_front();
				exp_name = name_q.pop_front();
				checks++;
				assert (pts_out == exp_pt) else begin
					errors++;
					$display("CHECK FAILED %s expected %h actual %h", exp_name, exp_pt, pts_out);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		fe_t         xb;
		fe_t         pm1;
		point_pair_t pp;
		point_pair_t chain_ref;
		logic [4:0]  scalar;
		seed   = 35532;
		arst_n = 1'b0;
		start  = 1'b0;
		x1     = '0;
		pts_in = '0;
		swap   = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// idle after reset
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			checks++;
			assert (!done && pts_out == '0) else begin
				errors++;
				$display("CHECK FAILED reset_idle expected done 0 pts_out 0 actual done %b pts_out %h",
					done, pts_out);
			end
		end

		// random points, no exchange then exchange
		for (int i = 0; i < 10; i++) begin
			xb = rand_fe();
			pp = rand_pair();
			launch($sformatf("swap0_%0d", i), xb, pp, 1'b0);
			wait_done();
		end
		for (int i = 0; i < 10; i++) begin
			xb = rand_fe();
			pp = rand_pair();
			launch($sformatf("swap1_%0d", i), xb, pp, 1'b1);
			wait_done();
		end

		// boundary operands
		pp      = rand_pair();
		pp.p0.z = '0;
		pp.p1.z = '0;
		launch("bound_z0", rand_fe(), pp, 1'b0);
		wait_done();
		pp      = rand_pair();
		pp.p0.z = fe_t'(1);
		pp.p1.z = fe_t'(1);
		launch("bound_z1", rand_fe(), pp, 1'b1);
		wait_done();
		pm1     = FIELD_P - fe_t'(1);
		pp.p0.x = pm1;
		pp.p0.z = pm1;
		pp.p1.x = pm1;
		pp.p1.z = pm1;
		launch("bound_pm1", pm1, pp, 1'b0);
		wait_done();
		// sum wraps to zero, 0 - (p-1) borrows
		pp.p0.x = pm1;
		pp.p0.z = fe_t'(1);
		pp.p1.x = '0;
		pp.p1.z = pm1;
		launch("bound_mix", fe_t'(9), pp, 1'b1);
		wait_done();

		// five ladder bits, output fed back
		scalar    = 5'b10110;
		xb        = fe_t'(9);
		pp.p0.x   = fe_t'(1);
		pp.p0.z   = '0;
		pp.p1.x   = xb;
		pp.p1.z   = fe_t'(1);
		chain_ref = pp;
		for (int i = 4; i >= 0; i--) begin
			chain_ref = ladder_ref(xb, chain_ref, scalar[i]);
			launch($sformatf("chain_bit%0d", i), xb, pp, scalar[i]);
			wait_done();
			pp = pts_out;
		end
		checks++;
		assert (pts_out == chain_ref) else begin
			errors++;
			$display("CHECK FAILED chain_final expected %h actual %h", chain_ref, pts_out);
		end

		// second start while busy must be dropped
		launch("busy_first", rand_fe(), rand_pair(), 1'b1);
		repeat (5) @(negedge clk);
		start  = 1'b1;
		x1     = rand_fe();
		pts_in = rand_pair();
		swap   = 1'b0;
		@(negedge clk);
		start = 1'b0;
		wait_done();
		// longer than one step, any extra done is flagged above
		repeat (3000) @(negedge clk);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
source/x25519_pkg.sv
source/fe_addsub.sv
source/fe_mult.sv
source/ladder_step_ctrl.sv
source/x25519_ladder_step.sv
verif/tb_x25519_ladder_step.sv
